// ==== common/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

  // Signed PCM sample as it sits in the buffer
  typedef logic signed [15:0] sample_t;

  localparam int SAMPLE_W    = 16;
  localparam int CIC_W       = 32;  // Width of one comb or integrator lane
  localparam int CIC_OUT_LSB = 12;  // Drops the 16^3 gain of the interpolator
  localparam int VOL_W       = 10;  // Scaled volume, up to about 4x

  // Volume multiply
  localparam int PROD_W   = SAMPLE_W + VOL_W;  // Signed product width
  localparam int PROD_LSB = 8;                 // Volume 256 is unity

  typedef struct packed {
    sample_t left;
    sample_t right;
  } stereo_t;

  // One buffer word, written by the host a byte at a time
  // and read back by the filter as a stereo pair
  typedef union packed {
    logic [3:0][7:0] bytes;  // Byte 0 right low, byte 3 left high
    stereo_t         stereo;
  } buf_word_u;

endpackage

`default_nettype wire

// ==== common/rate_pkg.sv ====
`default_nettype none

package rate_pkg;

  localparam int PHASE_W = 20;

  // sysclk / div * mul = 44100 * 16
  localparam logic [PHASE_W-1:0] PHASE_MUL_NTSC = 20'd1232;
  localparam logic [PHASE_W-1:0] PHASE_DIV_NTSC = 20'd37500;   // 21.477 MHz console
  localparam logic [PHASE_W-1:0] PHASE_MUL_PAL  = 20'd23520;
  localparam logic [PHASE_W-1:0] PHASE_DIV_PAL  = 20'd709379;  // 21.281 MHz console

  localparam int SUBSTEPS = 4;  // Counter width, 2**4 steps per word

  // I2S divider taps
  localparam int DIV_W    = 11;
  localparam int MCLK_BIT = 2;  // clkin / 8
  localparam int SCLK_BIT = 3;  // clkin / 16
  localparam int LRCK_BIT = 8;  // clkin / 512

endpackage

`default_nettype wire

// ==== design/sample_fetch.sv ====
`default_nettype none

module sample_fetch #(
  parameter int buf_addr_w = 9
) (
  input  wire                   clkin,
  input  wire                   reset,
  input  wire                   pgm_we,
  input  wire [buf_addr_w+1:0]  pgm_address,
  input  wire [7:0]             pgm_data,
  input  wire                   play,
  input  wire [buf_addr_w-1:0]  addr_init,
  input  wire                   word_strobe,
  output audio_pkg::buf_word_u  word,
  output logic                  buf_half
);
  import audio_pkg::*;

  localparam int depth = 2 ** buf_addr_w;

  buf_word_u             mem [depth];
  logic [buf_addr_w-1:0] rd_addr;
  logic                  play_r;

  //////////////////////////////////////////////////
  // Buffer RAM

  // Host side writes single bytes
  always_ff @(posedge clkin) begin
    if (pgm_we) begin
      mem[pgm_address[buf_addr_w+1:2]].bytes[pgm_address[1:0]] <= pgm_data;
    end
  end

  always_ff @(posedge clkin) begin
    word <= mem[rd_addr];  // One clock read latency
  end

  //////////////////////////////////////////////////
  // Read pointer

  always_ff @(posedge clkin) begin
    if (reset) begin
      rd_addr <= addr_init;
      play_r  <= 1'b0;
    end else begin
      play_r <= play;
      if (word_strobe) begin
        rd_addr <= rd_addr + buf_addr_w'(play_r);  // Wraps at buffer end
      end
    end
  end

  // Host refills the half not being read
  assign buf_half = rd_addr[buf_addr_w-1];

  addr_moves_on_word : assert property (@(posedge clkin) disable iff (reset)
    (!$past(word_strobe) && !$past(reset)) |-> $stable(rd_addr));

endmodule

`default_nettype wire

// ==== cic/rate_gen.sv ====
`default_nettype none

module rate_gen (
  input  wire  clkin,
  input  wire  reset,
  input  wire  sysclk,
  input  wire  palmode,
  output logic int_strobe,
  output logic word_strobe
);
  import rate_pkg::*;

  logic [2:0]          sysclk_sync;
  logic                sysclk_rise;
  logic [PHASE_W-1:0]  phase_acc;
  logic [PHASE_W-1:0]  phase_mul;
  logic [PHASE_W-1:0]  phase_div;
  logic [SUBSTEPS-1:0] substep;

  // Console clock is asynchronous to clkin
  always_ff @(posedge clkin) begin
    sysclk_sync <= {sysclk_sync[1:0], sysclk};
  end
  assign sysclk_rise = (sysclk_sync[2:1] == 2'b01);

  assign phase_mul = palmode ? PHASE_MUL_PAL : PHASE_MUL_NTSC;
  assign phase_div = palmode ? PHASE_DIV_PAL : PHASE_DIV_NTSC;

  always_ff @(posedge clkin) begin
    if (reset) begin
      phase_acc   <= '0;
      substep     <= '0;
      int_strobe  <= 1'b0;
      word_strobe <= 1'b0;
    end else begin
      int_strobe  <= 1'b0;
      word_strobe <= 1'b0;
      if (sysclk_rise) begin
        if (phase_acc >= phase_div) begin
          phase_acc  <= phase_acc - phase_div + phase_mul;
          substep    <= substep + 1'b1;
          int_strobe <= 1'b1;
          word_strobe <= (substep == '0);  // First step of each word
        end else begin
          phase_acc <= phase_acc + phase_mul;
        end
      end
    end
  end

  word_with_int : assert property (@(posedge clkin) disable iff (reset)
    word_strobe |-> int_strobe);

endmodule

`default_nettype wire

// ==== cic/cic_interpolator.sv ====
`default_nettype none

module cic_interpolator (
  input  wire                   clkin,
  input  wire                   reset,
  input  wire                   int_strobe,
  input  wire                   word_strobe,
  input  wire audio_pkg::buf_word_u word,
  output audio_pkg::sample_t    cic_left,
  output audio_pkg::sample_t    cic_right
);
  import audio_pkg::*;

  // One-hot sequencer states
  localparam logic [6:0] st_idle  = 7'b000_0001;
  localparam logic [6:0] st_comb1 = 7'b000_0010;
  localparam logic [6:0] st_comb2 = 7'b000_0100;
  localparam logic [6:0] st_comb3 = 7'b000_1000;
  localparam logic [6:0] st_int1  = 7'b001_0000;
  localparam logic [6:0] st_int2  = 7'b010_0000;
  localparam logic [6:0] st_int3  = 7'b100_0000;

  typedef logic [1:0][CIC_W-1:0] lanes_t;  // [1] left, [0] right

  logic [6:0] state;
  lanes_t     lane_in;
  lanes_t     ci [3];  // Previous comb inputs
  lanes_t     co [3];  // Comb outputs
  lanes_t     io [3];  // Integrator outputs

  function automatic lanes_t lane_sub(input lanes_t a, input lanes_t b);
    lane_sub[1] = a[1] - b[1];
    lane_sub[0] = a[0] - b[0];
  endfunction

  function automatic lanes_t lane_add(input lanes_t a, input lanes_t b);
    lane_add[1] = a[1] + b[1];  // Wraps modulo lane width
    lane_add[0] = a[0] + b[0];
  endfunction

  // Sign extend both channels into the lanes
  assign lane_in[1] = CIC_W'(word.stereo.left);
  assign lane_in[0] = CIC_W'(word.stereo.right);

  //////////////////////////////////////////////////
  // Sequencer and datapath

  always_ff @(posedge clkin) begin
    if (reset) begin
      state <= st_idle;
      for (int k = 0; k < 3; k++) begin
        ci[k] <= '0;
        co[k] <= '0;
        io[k] <= '0;
      end
    end else if (int_strobe) begin
      state <= word_strobe ? st_comb1 : st_int1;  // New word runs the combs first
    end else begin
      case (state)
        st_comb1: begin
          ci[0] <= lane_in;
          co[0] <= lane_sub(lane_in, ci[0]);
          state <= st_comb2;
        end
        st_comb2: begin
          ci[1] <= co[0];
          co[1] <= lane_sub(co[0], ci[1]);
          state <= st_comb3;
        end
        st_comb3: begin
          ci[2] <= co[1];
          co[2] <= lane_sub(co[1], ci[2]);
          state <= st_int1;
        end
        // Comb output is held between words
        st_int1: begin
          io[0] <= lane_add(co[2], io[0]);
          state <= st_int2;
        end
        st_int2: begin
          io[1] <= lane_add(io[0], io[1]);
          state <= st_int3;
        end
        st_int3: begin
          io[2] <= lane_add(io[1], io[2]);
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Slice gives unity DC gain
  assign cic_left  = io[2][1][CIC_OUT_LSB +: SAMPLE_W];
  assign cic_right = io[2][0][CIC_OUT_LSB +: SAMPLE_W];

  state_onehot : assert property (@(posedge clkin) disable iff (reset)
    $onehot(state));

endmodule

`default_nettype wire

// ==== design/volume_ramp.sv ====
`default_nettype none

module volume_ramp (
  input  wire                clkin,
  input  wire                reset,
  input  wire audio_pkg::sample_t cic_left,
  input  wire audio_pkg::sample_t cic_right,
  input  wire [7:0]          volume,
  input  wire [2:0]          vol_select,
  input  wire                frame_tick,
  output audio_pkg::sample_t out_left,
  output audio_pkg::sample_t out_right
);
  import audio_pkg::*;

  logic [VOL_W-1:0]        vol_base;
  logic [VOL_W-1:0]        vol_scaled;
  logic [VOL_W-1:0]        vol_target;
  logic [VOL_W-1:0]        vol_cur;
  logic signed [VOL_W:0]   vol_s;
  logic signed [PROD_W-1:0] prod_left;
  logic signed [PROD_W-1:0] prod_right;

  function automatic sample_t saturate(input logic signed [PROD_W-1:0] p);
    if (p[PROD_W-1 -: 3] == 3'b000 || p[PROD_W-1 -: 3] == 3'b111) begin
      saturate = p[PROD_LSB +: SAMPLE_W];
    end else if (p[PROD_W-1]) begin
      saturate = 16'sh8000;
    end else begin
      saturate = 16'sh7fff;
    end
  endfunction

  assign vol_base = VOL_W'(volume) + VOL_W'(volume[7]);  // 255 -> 256

  always_comb begin
    case (vol_select)
      3'd1: vol_scaled = vol_base + VOL_W'(volume[7:1]);             // +3 dB
      3'd2: vol_scaled = {vol_base[VOL_W-2:0], 1'b0};                // +6 dB
      3'd3: vol_scaled = VOL_W'({volume, 1'b0}) + VOL_W'(volume)
                         + VOL_W'(volume[7:6]);                      // +9 dB
      3'd4: vol_scaled = {volume, volume[7:6]};                      // +12 dB
      default: vol_scaled = vol_base;
    endcase
  end

  // Ramp one step per output frame to avoid clicks
  always_ff @(posedge clkin) begin
    if (reset) begin
      vol_target <= '0;
      vol_cur    <= '0;
    end else begin
      vol_target <= vol_scaled;
      if (frame_tick) begin
        if (vol_cur > vol_target) begin
          vol_cur <= vol_cur - 1'b1;
        end else if (vol_cur < vol_target) begin
          vol_cur <= vol_cur + 1'b1;
        end
      end
    end
  end

  assign vol_s = {1'b0, vol_cur};

  always_ff @(posedge clkin) begin
    prod_left  <= PROD_W'(cic_left) * PROD_W'(vol_s);
    prod_right <= PROD_W'(cic_right) * PROD_W'(vol_s);
  end

  assign out_left  = saturate(prod_left);
  assign out_right = saturate(prod_right);

  one_step_per_frame : assert property (@(posedge clkin) disable iff (reset)
    (vol_cur != $past(vol_cur)) |->
      ($past(frame_tick) &&
       (vol_cur == $past(vol_cur) + 10'd1 || vol_cur == $past(vol_cur) - 10'd1)));

endmodule

`default_nettype wire

// ==== i2s/i2s_serializer.sv ====
`default_nettype none

module i2s_serializer (
  input  wire                clkin,
  input  wire                reset,
  input  wire audio_pkg::sample_t out_left,
  input  wire audio_pkg::sample_t out_right,
  output logic               sdout,
  output logic               mclk_out,
  output logic               sclk_out,
  output logic               lrck_out,
  output logic               frame_tick
);
  import audio_pkg::*;
  import rate_pkg::*;

  logic [DIV_W-1:0] div_cnt;
  logic [1:0]       mclk_pipe;
  logic [1:0]       sclk_pipe;
  logic [1:0]       lrck_pipe;
  logic             sclk_fall;
  logic             lrck_rise;
  logic             lrck_fall;
  sample_t          shift_reg;

  // Edges seen against the first pipe stage
  assign sclk_fall = sclk_pipe[0] & ~div_cnt[SCLK_BIT];
  assign lrck_rise = ~lrck_pipe[0] & div_cnt[LRCK_BIT];
  assign lrck_fall = lrck_pipe[0] & ~div_cnt[LRCK_BIT];

  assign frame_tick = lrck_rise;  // Start of each stereo frame

  //////////////////////////////////////////////////
  // Divider and clock outputs

  always_ff @(posedge clkin) begin
    if (reset) begin
      div_cnt   <= '0;
      mclk_pipe <= '0;
      sclk_pipe <= '0;
      lrck_pipe <= '0;
    end else begin
      div_cnt   <= div_cnt + 1'b1;
      mclk_pipe <= {mclk_pipe[0], ~div_cnt[MCLK_BIT]};  // MCLK goes out inverted
      sclk_pipe <= {sclk_pipe[0], div_cnt[SCLK_BIT]};
      lrck_pipe <= {lrck_pipe[0], div_cnt[LRCK_BIT]};
    end
  end

  assign mclk_out = mclk_pipe[1];
  assign sclk_out = sclk_pipe[1];
  assign lrck_out = lrck_pipe[1];

  //////////////////////////////////////////////////
  // Data shifter

  // MSB lands one SCLK after the LRCK edge
  always_ff @(posedge clkin) begin
    if (reset) begin
      sdout     <= 1'b0;
      shift_reg <= '0;
    end else if (sclk_fall) begin
      sdout <= shift_reg[SAMPLE_W-1];
      if (lrck_rise) begin
        shift_reg <= out_left;  // Left while LRCK high
      end else if (lrck_fall) begin
        shift_reg <= out_right;
      end else begin
        shift_reg <= {shift_reg[SAMPLE_W-2:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/msu_audio_top.sv ====
`default_nettype none

module msu_audio_top #(
  parameter int buf_addr_w = 9
) (
  input  wire                  clkin,
  input  wire                  reset,
  input  wire                  sysclk,
  input  wire                  palmode,
  input  wire                  play,
  input  wire [buf_addr_w-1:0] addr_init,
  input  wire                  pgm_we,
  input  wire [buf_addr_w+1:0] pgm_address,
  input  wire [7:0]            pgm_data,
  input  wire [7:0]            volume,
  input  wire [2:0]            vol_select,
  output logic                 sdout,
  output logic                 mclk_out,
  output logic                 sclk_out,
  output logic                 lrck_out,
  output logic                 buf_half
);
  import audio_pkg::*;

  logic      int_strobe;
  logic      word_strobe;
  logic      frame_tick;
  buf_word_u word;
  sample_t   cic_left;
  sample_t   cic_right;
  sample_t   out_left;
  sample_t   out_right;

  // Decode
  sample_fetch #(
    .buf_addr_w (buf_addr_w)
  ) u_sample_fetch (
    .clkin, .reset, .pgm_we, .pgm_address, .pgm_data,
    .play, .addr_init, .word_strobe, .word, .buf_half
  );

  // Execute
  rate_gen u_rate_gen (
    .clkin, .reset, .sysclk, .palmode, .int_strobe, .word_strobe
  );

  cic_interpolator u_cic (
    .clkin, .reset, .int_strobe, .word_strobe, .word, .cic_left, .cic_right
  );

  // Result
  volume_ramp u_volume (
    .clkin, .reset, .cic_left, .cic_right, .volume, .vol_select,
    .frame_tick, .out_left, .out_right
  );

  i2s_serializer u_i2s (
    .clkin, .reset, .out_left, .out_right, .sdout,
    .mclk_out, .sclk_out, .lrck_out, .frame_tick
  );

endmodule

`default_nettype wire

// ==== testbench/tb_msu_audio.sv ====
`default_nettype none

module tb_msu_audio;
  timeunit 1ns;
  timeprecision 1ps;

  import audio_pkg::*;

  localparam int buf_addr_w = 9;
  localparam int buf_words  = 2 ** buf_addr_w;
  localparam int byte_aw    = buf_addr_w + 2;

  logic                  clkin;
  logic                  reset;
  logic                  sysclk;
  logic                  palmode;
  logic                  play;
  logic [buf_addr_w-1:0] addr_init;
  logic                  pgm_we;
  logic [byte_aw-1:0]    pgm_address;
  logic [7:0]            pgm_data;
  logic [7:0]            volume;
  logic [2:0]            vol_select;
  wire                   sdout;
  wire                   mclk_out;
  wire                   sclk_out;
  wire                   lrck_out;
  wire                   buf_half;

  int      errors;
  int      timeouts;
  int      frames_rx;
  bit      timed_out;
  integer  seed;
  string   current_test;
  sample_t rx_left [$];
  sample_t rx_right [$];

  msu_audio_top #(
    .buf_addr_w (buf_addr_w)
  ) u_dut (
    .clkin, .reset, .sysclk, .palmode, .play, .addr_init,
    .pgm_we, .pgm_address, .pgm_data, .volume, .vol_select,
    .sdout, .mclk_out, .sclk_out, .lrck_out, .buf_half
  );

  initial begin
    clkin = 1'b0;
    forever #10 clkin = ~clkin;
  end

  // Console clock, unrelated to clkin
  initial begin
    sysclk = 1'b0;
    forever #23.5 sysclk = ~sysclk;
  end

  //////////////////////////////////////////////////
  // Helpers

  task automatic after_edge();
    @(posedge clkin);
    #2;
  endtask

  task automatic report_mismatch(input string what, input logic signed [31:0] expected,
                                 input logic signed [31:0] actual);
    errors++;
    $display("Error in %s, %s: expected %0d, actual %0d", current_test, what, expected, actual);
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timeouts++;
    $display("Timeout in %s: %s", current_test, what);
  endtask

  task automatic apply_reset();
    after_edge();
    reset = 1'b1;
    after_edge();
    after_edge();
    reset = 1'b0;
  endtask

  // Volume the ramp heads for, per gain setting
  function automatic int target_volume(input int vol, input int sel);
    int base;
    base = vol + (vol >> 7);
    case (sel)
      1: return base + vol / 2;
      2: return 2 * base;
      3: return 3 * vol + (vol >> 6);
      4: return 4 * vol + (vol >> 6);
      default: return base;
    endcase
  endfunction

  function automatic sample_t expected_out(input sample_t x, input int vol);
    int p;
    p = int'(x) * vol;
    return sample_t'(p >>> 8);  // 256 is unity
  endfunction

  // Byte 0 is the right low byte, byte 3 the left high byte
  task automatic fill_buffer(input sample_t left, input sample_t right, input int first);
    logic [31:0] pair;
    int          w;
    pair = {left, right};
    for (int i = 0; i < buf_words; i++) begin
      w = (first + i) % buf_words;
      for (int b = 0; b < 4; b++) begin
        after_edge();
        pgm_we      = 1'b1;
        pgm_address = byte_aw'(w * 4 + b);
        pgm_data    = pair[8*b +: 8];
      end
    end
    after_edge();
    pgm_we = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // I2S receiver

  // Rising edge of sclk_out or lrck_out, sampled on falling clkin
  task automatic wait_rise(input bit on_lrck, input int limit);
    logic prev;
    logic now_val;
    if (timed_out) return;
    prev = on_lrck ? lrck_out : sclk_out;
    for (int n = 0; n < limit; n++) begin
      @(negedge clkin);
      now_val = on_lrck ? lrck_out : sclk_out;
      if (now_val && !prev) return;
      prev = now_val;
    end
    timed_out = 1'b1;
    report_timeout(on_lrck ? "no rising edge on lrck_out" : "no rising edge on sclk_out");
  endtask

  // Consecutive frames, left MSB on the second SCLK after LRCK rises
  task automatic get_frames(input int count);
    logic [31:0] bits;
    rx_left.delete();
    rx_right.delete();
    wait_rise(1'b1, 600);
    wait_rise(1'b0, 40);  // Last bit of the previous frame
    for (int f = 0; f < count; f++) begin
      for (int b = 0; b < 32; b++) begin
        wait_rise(1'b0, 40);
        bits = {bits[30:0], sdout};
      end
      if (!timed_out) begin
        rx_left.push_back(bits[31:16]);
        rx_right.push_back(bits[15:0]);
        frames_rx++;
      end
    end
  endtask

  // Frames are read every other one until the pair shows up
  task automatic settle_on(input sample_t exp_l, input sample_t exp_r, input int max_frames);
    bit hit;
    hit = 1'b0;
    for (int t = 0; t < max_frames / 2 && !hit && !timed_out; t++) begin
      get_frames(1);
      hit = !timed_out && rx_left[0] == exp_l && rx_right[0] == exp_r;
    end
    if (!hit && !timed_out) begin
      report_timeout($sformatf("output did not reach %0d/%0d within %0d frames",
                               exp_l, exp_r, max_frames));
    end
    get_frames(4);
    foreach (rx_left[i]) begin
      if (rx_left[i] != exp_l) report_mismatch("left", exp_l, rx_left[i]);
      if (rx_right[i] != exp_r) report_mismatch("right", exp_r, rx_right[i]);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests

  task automatic check_idle();
    if (sdout !== 1'b0) report_mismatch("sdout", 0, sdout);
    if (mclk_out !== 1'b0) report_mismatch("mclk_out", 0, mclk_out);
    if (sclk_out !== 1'b0) report_mismatch("sclk_out", 0, sclk_out);
    if (lrck_out !== 1'b0) report_mismatch("lrck_out", 0, lrck_out);
    if (buf_half !== addr_init[8]) report_mismatch("buf_half", addr_init[8], buf_half);
  endtask

  task automatic reset_state();
    current_test = "reset_state";
    @(posedge clkin);
    @(negedge clkin);
    check_idle();
    @(posedge clkin);
    #2;
    reset = 1'b0;
    @(negedge clkin);
    check_idle();
    @(negedge clkin);  // First cycle out of reset
    check_idle();
  endtask

  // MCLK is one eighth of clkin, high half the time
  task automatic check_mclk_rate();
    int   rises;
    int   highs;
    logic prev;
    current_test = "mclk_rate";
    rises = 0;
    highs = 0;
    @(negedge clkin);
    prev = mclk_out;
    for (int n = 0; n < 64; n++) begin
      @(negedge clkin);
      if (mclk_out && !prev) rises++;
      if (mclk_out) highs++;
      prev = mclk_out;
    end
    if (rises != 8) report_mismatch("mclk_out rising edges in 64 cycles", 8, rises);
    if (highs != 32) report_mismatch("mclk_out high cycles in 64 cycles", 32, highs);
  endtask

  task automatic dc_passthrough(input string name, input bit pal,
                                input sample_t left, input sample_t right);
    current_test = name;
    after_edge();
    palmode    = pal;
    volume     = 8'd255;
    vol_select = 3'd0;
    fill_buffer(left, right, int'(addr_init));
    settle_on(left, right, 300);
  endtask

  task automatic gain_and_saturation();
    sample_t small_l;
    sample_t small_r;
    small_l = 16'sh1234;
    small_r = -16'sd3000;
    current_test = "gain_and_saturation";
    after_edge();
    volume     = 8'd100;
    vol_select = 3'd2;
    fill_buffer(small_l, small_r, 0);
    settle_on(expected_out(small_l, target_volume(100, 2)),
              expected_out(small_r, target_volume(100, 2)), 200);
    // 385 times a large sample is far out of range
    after_edge();
    volume     = 8'd96;
    vol_select = 3'd4;
    fill_buffer(16'sh6000, -16'sh6000, 0);
    settle_on(16'sh7fff, 16'sh8000, 400);
  endtask

  task automatic ramp_down();
    sample_t left;
    sample_t right;
    int      step;
    int      last;
    left  = 16'sh4000;
    right = -16'sh2000;
    current_test = "volume_ramp";
    after_edge();
    volume     = 8'd255;
    vol_select = 3'd0;
    fill_buffer(left, right, 0);
    settle_on(left, right, 300);
    after_edge();
    volume = 8'd128;
    get_frames(150);
    step = (int'(left) + 255) / 256;  // One volume unit of the product
    for (int i = 1; i < rx_left.size(); i++) begin
      if (rx_left[i] > rx_left[i-1]) report_mismatch("left rose", rx_left[i-1], rx_left[i]);
      if (int'(rx_left[i-1]) - int'(rx_left[i]) > step) begin
        report_mismatch("left step size", step, int'(rx_left[i-1]) - int'(rx_left[i]));
      end
    end
    last = rx_left.size() - 1;
    if (last < 0) begin
      report_timeout("no frames received during the ramp");
    end else begin
      if (rx_left[last] != expected_out(left, target_volume(128, 0))) begin
        report_mismatch("left final", expected_out(left, target_volume(128, 0)), rx_left[last]);
      end
      if (rx_right[last] != expected_out(right, target_volume(128, 0))) begin
        report_mismatch("right final", expected_out(right, target_volume(128, 0)),
                        rx_right[last]);
      end
    end
  endtask

  task automatic play_and_status();
    bit seen;
    current_test = "play_and_status";
    after_edge();
    addr_init = 9'd255;
    play      = 1'b0;
    apply_reset();
    seen = 1'b0;
    for (int n = 0; n < 10000 && !seen; n++) begin  // About eight word periods
      @(negedge clkin);
      seen = buf_half;
    end
    if (seen) report_mismatch("buf_half while stopped", 0, 1);
    after_edge();
    play = 1'b1;
    seen = 1'b0;
    for (int n = 0; n < 4000 && !seen; n++) begin
      @(negedge clkin);
      seen = buf_half;
    end
    if (!seen) report_timeout("buf_half did not rise after play went high");
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial begin
    logic [31:0] rnd_l;
    logic [31:0] rnd_r;
    reset       = 1'b1;
    palmode     = 1'b0;
    play        = 1'b0;
    addr_init   = 9'h100;
    pgm_we      = 1'b0;
    pgm_address = '0;
    pgm_data    = '0;
    volume      = '0;
    vol_select  = '0;
    errors      = 0;
    timeouts    = 0;
    frames_rx   = 0;
    timed_out   = 1'b0;
    seed        = 32'hb2b88d50;

    reset_state();
    check_mclk_rate();
    dc_passthrough("dc_passthrough_ntsc", 1'b0, 16'sd12345, -16'sd20000);
    gain_and_saturation();
    ramp_down();
    play_and_status();
    rnd_l = $random(seed);
    rnd_r = $random(seed);
    dc_passthrough("dc_passthrough_pal", 1'b1, rnd_l[15:0], rnd_r[15:0]);

    $display("Run complete: %0d errors, %0d timeouts, %0d frames received",
             errors, timeouts, frames_rx);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== msu_audio.f ====
common/audio_pkg.sv
common/rate_pkg.sv
design/sample_fetch.sv
cic/rate_gen.sv
cic/cic_interpolator.sv
design/volume_ramp.sv
i2s/i2s_serializer.sv
design/msu_audio_top.sv
testbench/tb_msu_audio.sv

// ==== Makefile ====
TOP = tb_msu_audio
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f msu_audio.f --top-module $(TOP) --Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
